/* include/rob_defines.svh */
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// nick 0 means "no producer", so the buffer holds one less than 2**NICK_W
`define ROB_NICK_W 5
`define ROB_DEPTH 31

// architectural register name
`define REG_NAME_W 5

`define DATA_W 32
`define ADDR_W 32

// per-source completion FIFO
`define CQ_DEPTH 4

`endif

/* design/robPkg.sv */
`default_nettype none

`include "rob_defines.svh"

package robPkg;

    typedef logic [`ROB_NICK_W-1:0] nickT;

    // result from the execution unit
    typedef struct packed {
        nickT                nick;
        logic [`DATA_W-1:0]  data;
        logic                actualTaken;  // resolved branch direction
        logic [`ADDR_W-1:0]  targetPc;     // redirect pc on mispredict
    } exResultT;

    // load data from the store/load buffer
    typedef struct packed {
        nickT                nick;
        logic [`DATA_W-1:0]  data;
    } slbResultT;

endpackage

`default_nettype wire

/* design/completionQueue.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rob_defines.svh"

module completionQueue #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    flush,
    input  logic    inValid,
    input  payloadT inItem,
    output logic    inReady,
    output logic    outValid,
    output payloadT outItem,
    input  logic    pop
);

    localparam int PtrW = $clog2(`CQ_DEPTH);
    localparam logic [PtrW:0] FullCount = (PtrW + 1)'(`CQ_DEPTH);
    localparam logic [PtrW-1:0] LastSlot = PtrW'(`CQ_DEPTH - 1);

    payloadT mem [`CQ_DEPTH];

    logic [PtrW-1:0] rdPtr;
    logic [PtrW-1:0] wrPtr;
    logic [PtrW:0]   count;
    logic            push;
    logic            doPop;

    assign inReady  = (count != FullCount);  // back-pressure
    assign outValid = (count != '0);
    assign outItem  = mem[rdPtr];

    assign push  = inValid && inReady;
    assign doPop = pop && outValid;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == LastSlot) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == LastSlot) ? '0 : rdPtr + 1'b1;
            end
            case ({push, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= inItem;
        end
    end

    // the arbiter only pops a queue that shows valid
    assert property (@(posedge clk) disable iff (rst || flush) pop |-> outValid);

    // never more than the depth, and the pointers agree with the count
    assert property (@(posedge clk) disable iff (rst || flush)
        count <= FullCount && PtrW'(wrPtr - rdPtr) == count[PtrW-1:0]);

endmodule

`default_nettype wire

/* design/renameTable.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rob_defines.svh"

module renameTable (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic                   allocEn,
    input  logic [`REG_NAME_W-1:0] allocRegName,
    input  robPkg::nickT           allocNick,
    input  logic                   commitEn,
    input  logic [`REG_NAME_W-1:0] commitRegName,
    input  robPkg::nickT           commitNick,
    input  logic [`REG_NAME_W-1:0] lookupRegName,
    output logic                   lookupBusy,
    output robPkg::nickT           lookupNick
);

    localparam int NumRegs = 1 << `REG_NAME_W;

    logic [NumRegs-1:0] busy;
    robPkg::nickT       mapNick [NumRegs];

    // x0 is hardwired, never renamed
    assign lookupBusy = busy[lookupRegName] && (lookupRegName != '0);
    assign lookupNick = lookupBusy ? mapNick[lookupRegName] : '0;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy <= '0;
        end else begin
            // only the youngest writer frees the register
            if (commitEn && busy[commitRegName] && mapNick[commitRegName] == commitNick) begin
                busy[commitRegName] <= 1'b0;
            end
            if (allocEn && allocRegName != '0) begin
                busy[allocRegName] <= 1'b1;  // wins over a same-edge clear
            end
        end
    end

    always_ff @(posedge clk) begin
        if (allocEn) begin
            mapNick[allocRegName] <= allocNick;
        end
    end

endmodule

`default_nettype wire

/* design/robControl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rob_defines.svh"

module robControl (
    input  logic         clk,
    input  logic         rst,
    input  logic         allocReq,
    input  logic         allocIsStore,
    input  logic         allocPredTaken,
    output logic         allocGrant,
    output logic         robFull,
    output robPkg::nickT allocNick,
    input  logic         exQValid,
    input  logic         slbQValid,
    output logic         exQPop,
    output logic         slbQPop,
    output robPkg::nickT headNick,
    input  logic         headDone,
    input  logic         headIsStore,
    input  logic         headMispredict,
    output logic         wrSel,
    output logic         wrEn,
    output logic         commitEn,
    output logic         commitIsStore,
    output logic         flush
);

    localparam logic [`ROB_NICK_W-1:0] Depth = `ROB_NICK_W'(`ROB_DEPTH);
    localparam robPkg::nickT FirstNick = robPkg::nickT'(1);

    robPkg::nickT           headPtr;
    robPkg::nickT           tailPtr;
    logic [`ROB_NICK_W-1:0] count;
    logic [`ROB_NICK_W-1:0] ptrDist;
    logic                   empty;
    logic                   mispredictCommit;

    function automatic robPkg::nickT nextNick(input robPkg::nickT p);
        return (p == Depth) ? FirstNick : p + 1'b1;  // skip nick 0
    endfunction

    assign empty   = (count == '0);
    assign robFull = (count == Depth);

    // wraps over the usable nicks only
    assign ptrDist = (tailPtr >= headPtr) ? tailPtr - headPtr : tailPtr + Depth - headPtr;

    assign allocGrant = allocReq && !robFull && !flush;
    assign allocNick  = tailPtr;
    assign headNick   = headPtr;

    // stores leave as soon as they reach the head
    assign commitEn      = !empty && (headDone || headIsStore) && !flush;
    assign commitIsStore = headIsStore;

    assign mispredictCommit = commitEn && !headIsStore && headMispredict;

    // one write port, ex first
    assign exQPop  = exQValid && !flush;
    assign slbQPop = slbQValid && !exQValid && !flush;
    assign wrEn    = exQPop || slbQPop;
    assign wrSel   = slbQPop;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            headPtr <= FirstNick;
            tailPtr <= FirstNick;
            count   <= '0;
        end else begin
            if (allocGrant) begin
                tailPtr <= nextNick(tailPtr);
            end
            if (commitEn) begin
                headPtr <= nextNick(headPtr);
            end
            case ({allocGrant, commitEn})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // lasts one cycle, everything clears on the next edge
    always_ff @(posedge clk) begin
        if (rst) begin
            flush <= 1'b0;
        end else begin
            flush <= mispredictCommit;
        end
    end

    // occupancy matches the pointer distance, full when the pointers meet
    assert property (@(posedge clk) disable iff (rst)
        (count == ptrDist) || (robFull && ptrDist == '0));

    // a grant never lands on the live head slot
    assert property (@(posedge clk) disable iff (rst)
        allocGrant |-> (empty || tailPtr != headPtr));

endmodule

`default_nettype wire

/* design/robEntryStore.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rob_defines.svh"

module robEntryStore (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic                   allocEn,
    input  robPkg::nickT           allocNick,
    input  logic [`REG_NAME_W-1:0] allocRegName,
    input  logic                   allocIsStore,
    input  logic                   allocPredTaken,
    input  logic                   wrEn,
    input  logic                   wrSel,
    input  robPkg::exResultT       exItem,
    input  robPkg::slbResultT      slbItem,
    input  robPkg::nickT           headNick,
    input  logic                   commitEn,
    input  logic                   commitIsStore,
    output logic                   headDone,
    output logic                   headIsStore,
    output logic                   headMispredict,
    output logic                   rfWriteValid,
    output logic                   storeCommitValid,
    output logic                   flushValid,
    output logic [`REG_NAME_W-1:0] rfWriteRegName,
    output logic [`DATA_W-1:0]     rfWriteData,
    output robPkg::nickT           rfWriteNick,
    output robPkg::nickT           storeCommitNick,
    output logic [`ADDR_W-1:0]     flushPc
);

    localparam int Slots = 1 << `ROB_NICK_W;

    logic [Slots-1:0] valid;
    logic [Slots-1:0] done;

    logic [`REG_NAME_W-1:0] regName     [Slots];
    logic [`DATA_W-1:0]     data        [Slots];
    logic [`ADDR_W-1:0]     targetPc    [Slots];
    logic                   isStore     [Slots];
    logic                   predTaken   [Slots];
    logic                   actualTaken [Slots];

    robPkg::nickT       wrNick;
    logic [`DATA_W-1:0] wrData;

    assign wrNick = wrSel ? slbItem.nick : exItem.nick;
    assign wrData = wrSel ? slbItem.data : exItem.data;

    assign headDone       = valid[headNick] && done[headNick];
    assign headIsStore    = isStore[headNick];
    assign headMispredict = predTaken[headNick] != actualTaken[headNick];

    assign flushValid = flush;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid <= '0;
            done  <= '0;
        end else begin
            if (commitEn) begin
                valid[headNick] <= 1'b0;
            end
            if (allocEn) begin
                valid[allocNick] <= 1'b1;
                done[allocNick]  <= 1'b0;
            end
            if (wrEn) begin
                done[wrNick] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (allocEn) begin
            regName[allocNick]     <= allocRegName;
            isStore[allocNick]     <= allocIsStore;
            predTaken[allocNick]   <= allocPredTaken;
            actualTaken[allocNick] <= allocPredTaken;  // loads never redirect
        end
        if (wrEn) begin
            data[wrNick] <= wrData;
            if (!wrSel) begin
                actualTaken[wrNick] <= exItem.actualTaken;
                targetPc[wrNick]    <= exItem.targetPc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rfWriteValid     <= 1'b0;
            storeCommitValid <= 1'b0;
        end else begin
            rfWriteValid     <= commitEn && !commitIsStore;
            storeCommitValid <= commitEn && commitIsStore;
        end
    end

    // head fields, seen the cycle after commit
    always_ff @(posedge clk) begin
        if (commitEn) begin
            rfWriteRegName  <= regName[headNick];
            rfWriteData     <= data[headNick];
            rfWriteNick     <= headNick;
            storeCommitNick <= headNick;
            flushPc         <= targetPc[headNick];
        end
    end

    // a result popped from either queue must name a live entry
    assert property (@(posedge clk) disable iff (rst || flush) wrEn |-> valid[wrNick]);

endmodule

`default_nettype wire

/* design/robTop.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rob_defines.svh"

module robTop (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   allocReq,
    input  logic [`REG_NAME_W-1:0] allocRegName,
    input  logic                   allocIsStore,
    input  logic                   allocPredTaken,
    output logic                   allocGrant,
    output robPkg::nickT           allocNick,
    output logic                   robFull,
    input  logic                   exValid,
    input  robPkg::nickT           exNick,
    input  logic [`DATA_W-1:0]     exData,
    input  logic                   exActualTaken,
    input  logic [`ADDR_W-1:0]     exTargetPc,
    output logic                   exReady,
    input  logic                   slbValid,
    input  robPkg::nickT           slbNick,
    input  logic [`DATA_W-1:0]     slbData,
    output logic                   slbReady,
    output logic                   storeCommitValid,
    output robPkg::nickT           storeCommitNick,
    output logic                   rfWriteValid,
    output logic [`REG_NAME_W-1:0] rfWriteRegName,
    output logic [`DATA_W-1:0]     rfWriteData,
    output robPkg::nickT           rfWriteNick,
    output logic                   flushValid,
    output logic [`ADDR_W-1:0]     flushPc,
    input  logic [`REG_NAME_W-1:0] lookupRegName,
    output logic                   lookupBusy,
    output robPkg::nickT           lookupNick
);

    robPkg::exResultT  exHead;
    robPkg::slbResultT slbHead;
    robPkg::nickT      headNick;

    logic exQValid, slbQValid, exQPop, slbQPop;
    logic headDone, headIsStore, headMispredict;
    logic wrSel, wrEn, commitEn, commitIsStore, flush;

    completionQueue #(.payloadT(robPkg::exResultT)) exQueue (
        .clk(clk), .rst(rst), .flush(flush),
        .inValid(exValid),
        .inItem(robPkg::exResultT'{exNick, exData, exActualTaken, exTargetPc}),
        .inReady(exReady),
        .outValid(exQValid), .outItem(exHead), .pop(exQPop)
    );

    completionQueue #(.payloadT(robPkg::slbResultT)) slbQueue (
        .clk(clk), .rst(rst), .flush(flush),
        .inValid(slbValid),
        .inItem(robPkg::slbResultT'{slbNick, slbData}),
        .inReady(slbReady),
        .outValid(slbQValid), .outItem(slbHead), .pop(slbQPop)
    );

    robControl control (
        .clk(clk), .rst(rst),
        .allocReq(allocReq), .allocIsStore(allocIsStore), .allocPredTaken(allocPredTaken),
        .allocGrant(allocGrant), .robFull(robFull), .allocNick(allocNick),
        .exQValid(exQValid), .slbQValid(slbQValid), .exQPop(exQPop), .slbQPop(slbQPop),
        .headNick(headNick), .headDone(headDone), .headIsStore(headIsStore),
        .headMispredict(headMispredict),
        .wrSel(wrSel), .wrEn(wrEn),
        .commitEn(commitEn), .commitIsStore(commitIsStore), .flush(flush)
    );

    robEntryStore entries (
        .clk(clk), .rst(rst), .flush(flush),
        .allocEn(allocGrant), .allocNick(allocNick), .allocRegName(allocRegName),
        .allocIsStore(allocIsStore), .allocPredTaken(allocPredTaken),
        .wrEn(wrEn), .wrSel(wrSel), .exItem(exHead), .slbItem(slbHead),
        .headNick(headNick), .commitEn(commitEn), .commitIsStore(commitIsStore),
        .headDone(headDone), .headIsStore(headIsStore), .headMispredict(headMispredict),
        .rfWriteValid(rfWriteValid), .storeCommitValid(storeCommitValid),
        .flushValid(flushValid),
        .rfWriteRegName(rfWriteRegName), .rfWriteData(rfWriteData), .rfWriteNick(rfWriteNick),
        .storeCommitNick(storeCommitNick), .flushPc(flushPc)
    );

    // freed by the registered writeback, same edge the regfile takes it
    renameTable rename (
        .clk(clk), .rst(rst), .flush(flush),
        .allocEn(allocGrant), .allocRegName(allocRegName), .allocNick(allocNick),
        .commitEn(rfWriteValid), .commitRegName(rfWriteRegName), .commitNick(rfWriteNick),
        .lookupRegName(lookupRegName), .lookupBusy(lookupBusy), .lookupNick(lookupNick)
    );

endmodule

`default_nettype wire

/* tests/robTb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rob_defines.svh"

module robTb;

    localparam int Timeout = 200;

    typedef enum logic [3:0] {
        OpAlloc, OpEx, OpSlb, OpBoth, OpIdle, OpLookup, OpDrain, OpStall, OpEnd
    } opT;

    // one row of the stimulus table
    typedef struct packed {
        opT                     op;
        logic [`REG_NAME_W-1:0] regName;
        logic                   isStore;
        logic                   pred;
        robPkg::nickT           nick;   // also idle cycle count
        robPkg::nickT           nick2;  // slb nick for OpBoth
        logic                   actual;
        logic [`ADDR_W-1:0]     target;
        logic                   expOk;  // grant or busy expected
    } stepT;

    // scoreboard entry, kept in allocation order
    typedef struct packed {
        robPkg::nickT           nick;
        logic [`REG_NAME_W-1:0] regName;
        logic                   isStore;
        logic                   pred;
        logic                   actual;
        logic [`DATA_W-1:0]     data;
        logic [`ADDR_W-1:0]     target;
    } entryT;

    logic clk, rst;
    logic allocReq, allocIsStore, allocPredTaken, allocGrant, robFull;
    logic [`REG_NAME_W-1:0] allocRegName, rfWriteRegName, lookupRegName;
    robPkg::nickT allocNick, exNick, slbNick, storeCommitNick, rfWriteNick, lookupNick;
    logic exValid, exActualTaken, exReady, slbValid, slbReady;
    logic [`DATA_W-1:0] exData, slbData, rfWriteData;
    logic [`ADDR_W-1:0] exTargetPc, flushPc;
    logic storeCommitValid, rfWriteValid, flushValid, lookupBusy;

    stepT  steps[$];
    entryT model[$];
    int    errors = 0;
    int    passed = 0;
    int    failed = 0;
    int    testNum = 0;
    int    errorsAtStart = 0;
    bit    sawSlbStall = 0;
    bit    timedOut = 0;
    string names [6] = '{"alloc order and full", "out of order completion",
                         "rename lookup", "store commit", "mispredict flush",
                         "ex/slb contention"};

    robTop uut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic reportError(input string msg);
        errors++;
        $display("ERROR: %s", msg);
    endtask

    task automatic flagTimeout(input string msg);
        errors++;
        timedOut = 1;
        $display("TIMEOUT: %s", msg);
    endtask

    function automatic void addStep(opT op, int rn = 0, bit st = 0, bit pr = 0, int nk = 0,
                                    int nk2 = 0, bit act = 0, int tgt = 0, bit ok = 1);
        steps.push_back('{op, rn[`REG_NAME_W-1:0], st, pr, nk[`ROB_NICK_W-1:0],
                          nk2[`ROB_NICK_W-1:0], act, tgt[`ADDR_W-1:0], ok});
    endfunction

    function automatic void buildTable();
        for (int i = 1; i <= 31; i++) addStep(OpAlloc, (i % 31) + 1, 0, 0, i);
        addStep(OpAlloc, 3, 0, 0, 0, 0, 0, 0, 0);  // refused, buffer full
        addStep(OpEx, 0, 0, 0, 1);
        addStep(OpIdle, 0, 0, 0, 4);
        addStep(OpAlloc, 9, 0, 0, 1);  // wrapped
        addStep(OpEnd);
        for (int i = 1; i <= 4; i++) addStep(OpAlloc, i, 0, 0, i);
        addStep(OpEx, 0, 0, 0, 3);
        addStep(OpSlb, 0, 0, 0, 1);
        addStep(OpEx, 0, 0, 0, 4);
        addStep(OpEx, 0, 0, 0, 2);
        addStep(OpDrain);
        addStep(OpEnd);
        addStep(OpAlloc, 5, 0, 0, 1);
        addStep(OpAlloc, 5, 0, 0, 2);
        addStep(OpLookup, 5, 0, 0, 2);
        addStep(OpLookup, 0, 0, 0, 0, 0, 0, 0, 0);
        addStep(OpAlloc, 0, 0, 0, 3);
        addStep(OpLookup, 0, 0, 0, 0, 0, 0, 0, 0);  // x0 never busy
        addStep(OpSlb, 0, 0, 0, 1);
        addStep(OpIdle, 0, 0, 0, 6);
        addStep(OpLookup, 5, 0, 0, 2);  // older writer gone, still busy
        addStep(OpEx, 0, 0, 0, 2);
        addStep(OpEx, 0, 0, 0, 3);
        addStep(OpDrain);
        addStep(OpIdle, 0, 0, 0, 2);
        addStep(OpLookup, 5, 0, 0, 0, 0, 0, 0, 0);
        addStep(OpEnd);
        addStep(OpAlloc, 7, 1, 0, 1);
        addStep(OpAlloc, 8, 0, 0, 2);
        addStep(OpAlloc, 9, 1, 0, 3);
        addStep(OpEx, 0, 0, 0, 2);
        addStep(OpDrain);
        addStep(OpEnd);
        addStep(OpAlloc, 1, 0, 1, 1);  // branch predicted taken
        addStep(OpAlloc, 2, 0, 0, 2);
        addStep(OpAlloc, 3, 0, 0, 3);
        addStep(OpEx, 0, 0, 0, 2);
        addStep(OpEx, 0, 0, 0, 3);
        addStep(OpEx, 0, 0, 0, 1, 0, 0, 'h480);
        addStep(OpDrain);
        addStep(OpIdle, 0, 0, 0, 2);
        addStep(OpAlloc, 4, 0, 0, 1);
        addStep(OpEx, 0, 0, 0, 1);
        addStep(OpDrain);
        addStep(OpEnd);
        for (int i = 1; i <= 10; i++) addStep(OpAlloc, i, 0, 0, i);
        for (int i = 1; i <= 5; i++) addStep(OpBoth, 0, 0, 0, 5 + i, i);
        addStep(OpStall);
        addStep(OpDrain);
        addStep(OpEnd);
    endfunction

    task automatic driveDefaults();
        allocReq <= 1'b0;
        exValid  <= 1'b0;
        slbValid <= 1'b0;
    endtask

    task automatic resetDut();
        @(posedge clk);
        driveDefaults();
        rst <= 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        model.delete();
        sawSlbStall = 0;
        @(negedge clk);
        checkValue("allocGrant", 32'(allocGrant), 0);
        checkValue("exReady", 32'(exReady), 1);
        checkValue("slbReady", 32'(slbReady), 1);
        checkValue("robFull", 32'(robFull), 0);
        checkValue("rfWriteValid", 32'(rfWriteValid), 0);
        checkValue("storeCommitValid", 32'(storeCommitValid), 0);
        checkValue("flushValid", 32'(flushValid), 0);
    endtask

    task automatic recordResult(input robPkg::nickT nick, input logic [31:0] d, input bit fromEx,
                                input logic act, input logic [31:0] tgt);
        bit found;
        found = 0;
        foreach (model[i]) begin
            if (model[i].nick == nick) begin
                found = 1;
                model[i].data = d;
                if (fromEx) begin
                    model[i].actual = act;
                    model[i].target = tgt;
                end
            end
        end
        if (!found) reportError("completion names a nick with no live entry");
    endtask

    // hold valid until each side sees ready, then let it go
    task automatic waitTransfer(input bit wantEx, input bit wantSlb);
        bit exLeft, slbLeft;
        int cycles;
        exLeft = wantEx;
        slbLeft = wantSlb;
        cycles = 0;
        while (exLeft || slbLeft) begin
            @(negedge clk);
            if (!slbReady) sawSlbStall = 1;
            if (exLeft && exReady) exLeft = 0;
            if (slbLeft && slbReady) slbLeft = 0;
            cycles++;
            if (cycles > Timeout) begin
                flagTimeout("completion handshake never accepted");
                break;
            end
            if (exLeft || slbLeft) begin
                @(posedge clk);
                if (!exLeft) exValid <= 1'b0;
                if (!slbLeft) slbValid <= 1'b0;
            end
        end
    endtask

    task automatic applyStep(input stepT s);
        logic [31:0] d, d2;
        entryT e;
        int cycles;
        d = $urandom;
        d2 = $urandom;
        case (s.op)
            OpAlloc: begin
                @(posedge clk);
                driveDefaults();
                allocReq       <= 1'b1;
                allocRegName   <= s.regName;
                allocIsStore   <= s.isStore;
                allocPredTaken <= s.pred;
                @(negedge clk);
                checkValue("allocGrant", 32'(allocGrant), 32'(s.expOk));
                if (!s.expOk) checkValue("robFull", 32'(robFull), 1);
                if (s.expOk && allocGrant) begin
                    checkValue("allocNick", 32'(allocNick), 32'(s.nick));
                    e = '{s.nick, s.regName, s.isStore, s.pred, s.pred, '0, '0};
                    model.push_back(e);
                end
            end
            OpEx, OpSlb, OpBoth: begin
                @(posedge clk);
                driveDefaults();
                if (s.op != OpSlb) begin
                    exValid <= 1'b1;
                    exNick <= s.nick;
                    exData <= d;
                    exActualTaken <= s.actual;
                    exTargetPc <= s.target;
                    recordResult(s.nick, d, 1, s.actual, s.target);
                end
                if (s.op != OpEx) begin
                    slbValid <= 1'b1;
                    slbNick <= (s.op == OpBoth) ? s.nick2 : s.nick;
                    slbData <= d2;
                    recordResult((s.op == OpBoth) ? s.nick2 : s.nick, d2, 0, 0, 0);
                end
                waitTransfer(s.op != OpSlb, s.op != OpEx);
            end
            OpIdle: begin
                repeat (s.nick) begin
                    @(posedge clk);
                    driveDefaults();
                end
            end
            OpLookup: begin
                @(posedge clk);
                driveDefaults();
                lookupRegName <= s.regName;
                @(negedge clk);
                checkValue("lookupBusy", 32'(lookupBusy), 32'(s.expOk));
                checkValue("lookupNick", 32'(lookupNick), 32'(s.nick));
            end
            OpDrain: begin
                @(posedge clk);
                driveDefaults();
                cycles = 0;
                while (model.size() != 0) begin
                    @(negedge clk);
                    cycles++;
                    if (cycles > Timeout) begin
                        flagTimeout("outstanding entries never committed");
                        break;
                    end
                end
            end
            OpStall: begin
                if (!sawSlbStall) reportError("slbReady never dropped under contention");
            end
            default: ;
        endcase
    endtask

    // scoreboard for the commit stream
    always @(negedge clk) begin
        entryT e;
        bit mis;
        if (!rst && (rfWriteValid || storeCommitValid)) begin
            if (model.size() == 0) begin
                reportError("commit seen with no entry outstanding");
            end else begin
                e = model.pop_front();
                mis = !e.isStore && (e.pred != e.actual);
                checkValue("storeCommitValid", 32'(storeCommitValid), 32'(e.isStore));
                checkValue("rfWriteValid", 32'(rfWriteValid), 32'(!e.isStore));
                if (e.isStore) begin
                    checkValue("storeCommitNick", 32'(storeCommitNick), 32'(e.nick));
                end else begin
                    checkValue("rfWriteNick", 32'(rfWriteNick), 32'(e.nick));
                    checkValue("rfWriteRegName", 32'(rfWriteRegName), 32'(e.regName));
                    checkValue("rfWriteData", rfWriteData, e.data);
                end
                checkValue("flushValid", 32'(flushValid), 32'(mis));
                if (mis) begin
                    checkValue("flushPc", flushPc, e.target);
                    model.delete();  // younger entries are gone
                end
            end
        end else if (!rst && flushValid) begin
            reportError("flush raised without a commit");
        end
    end

    initial begin
        rst = 1'b1;
        allocReq = 1'b0;
        allocRegName = '0;
        allocIsStore = 1'b0;
        allocPredTaken = 1'b0;
        exValid = 1'b0;
        exNick = '0;
        exData = '0;
        exActualTaken = 1'b0;
        exTargetPc = '0;
        slbValid = 1'b0;
        slbNick = '0;
        slbData = '0;
        lookupRegName = '0;
        void'($urandom(68932));
        buildTable();
        resetDut();
        errorsAtStart = errors;
        foreach (steps[i]) begin
            if (timedOut) break;
            if (steps[i].op == OpEnd) begin
                if (errors == errorsAtStart) begin
                    passed++;
                    $display("test %0d %s: ok", testNum + 1, names[testNum]);
                end else begin
                    failed++;
                    $display("test %0d %s: %0d errors", testNum + 1, names[testNum],
                             errors - errorsAtStart);
                end
                testNum++;
                resetDut();
                errorsAtStart = errors;
            end else begin
                applyStep(steps[i]);
            end
        end
        $display("%0d tests passed, %0d failed, %0d errors", passed, failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
design/robPkg.sv
design/completionQueue.sv
design/renameTable.sv
design/robControl.sv
design/robEntryStore.sv
design/robTop.sv
tests/robTb.sv

/* run.sh */
#!/bin/sh
# build the ROB testbench with Verilator and run it, log goes to sim.log
rm -rf obj_dir sim.log
( verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module robTb -o robSim \
    && ./obj_dir/robSim ) > sim.log 2>&1 \
    || echo "FAIL: see errors above" >> sim.log
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0
